// File: filelist.f
+incdir+.
mcu_pkg.sv
power_domain_ctrl.sv
power_manager.sv
irq_ctrl.sv
domain_iso_reg.sv
mini_mcu_ctrl.sv
mini_mcu_ctrl_assert.sv
tb_mini_mcu_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mini_mcu_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_mini_mcu_ctrl.sv
// --------------------
// testbench for the mcu control top
// lfsr stimulus against a reference model
// --------------------
`timescale 1ns/10ps
`include "mcu_settings.svh"

module tb_mini_mcu_ctrl;

  import mcu_pkg::*;

  localparam int N_RAND1 = 1500;
  localparam int N_QUIET = 200;
  localparam int N_HOLD  = 100;
  localparam int N_RAND2 = 1000;
  localparam int N_TOTAL = N_RAND1 + N_QUIET + N_HOLD + N_RAND2;
  localparam int ND      = 2 + `NUM_BANKS;
  localparam int S_ON = 0, S_CLK_OFF = 1, S_RST_ON = 3, S_SW_OFF = 4;
  localparam int S_OFF = 5, S_SW_ON = 6, S_RST_OFF = 7, S_ISO_OFF = 8;

  logic clk_i, reset_i, ndmreset_i, cpu_pd_en_i, core_sleep_i, periph_off_i;
  logic [`NUM_BANKS-1:0] bank_off_i;
  logic [ND-1:0] ack_n;
  pwr_ctrl_out_t cpu_pwr_o, periph_pwr_o;
  pwr_ctrl_out_t [`NUM_BANKS-1:0] bank_pwr_o;
  fast_src_t fast_src_i;
  periph_irq_t periph_irq_i;
  logic irq_timer0_i, irq_ack_i;
  logic [4:0] irq_id_i;
  gpio_pad_t periph_gpio_i, gpio_o;
  logic [`IRQ_W-1:0] irq_o;

  // model state for the cpu, the peripheral domain and the banks
  int          m_state [ND];
  logic [4:0]  m_seq [ND];
  int          ack_wait [ND];
  logic [13:0] m_pend;
  logic [1:0]  m_piso;
  logic [47:0] m_gpio;
  logic [31:0] lfsr = 32'hb36f;
  int          errors = 0;
  bit          chk_en = 0;

  mini_mcu_ctrl u_dut (
    .clk_i, .reset_i, .ndmreset_i, .cpu_pd_en_i, .core_sleep_i, .periph_off_i, .bank_off_i,
    .cpu_ack_ni (ack_n[0]), .periph_ack_ni (ack_n[1]), .bank_ack_ni (ack_n[ND-1:2]),
    .cpu_pwr_o, .periph_pwr_o, .bank_pwr_o, .fast_src_i, .periph_irq_i, .irq_timer0_i,
    .irq_ack_i, .irq_id_i, .periph_gpio_i, .gpio_o, .irq_o
  );

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  // fields {pwrgate, iso, rst, clkgate, spare}
  function automatic logic [4:0] seq_out(input int s);
    logic pg, iso, rst;
    pg  = !(s == S_SW_OFF || s == S_OFF);
    iso = (s == S_ON || s == S_CLK_OFF || s == S_ISO_OFF);
    rst = !(s == S_RST_ON || s == S_SW_OFF || s == S_OFF || s == S_SW_ON);
    return {pg, iso, rst, (s == S_ON), 1'b1};
  endfunction

  function automatic int seq_next(input int s, input logic req, input logic ack);
    case (s)
      S_ON:     return req ? S_CLK_OFF : S_ON;
      S_SW_OFF: return !ack ? S_OFF : S_SW_OFF;
      S_OFF:    return !req ? S_SW_ON : S_OFF;
      S_SW_ON:  return ack ? S_RST_OFF : S_SW_ON;
      S_ISO_OFF: return S_ON;
      default:  return s + 1;
    endcase
  endfunction

  function automatic logic [31:0] exp_vec(input logic [13:0] pend, input logic [1:0] piso,
                                          input logic t0);
    logic [31:0] v;
    v = '0;
    v[3]     = piso[0];
    v[7]     = t0;
    v[11]    = piso[1];
    v[29:16] = pend;
    return v;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // switch cells answer after 0 to 7 cycles
  task automatic ack_step();
    for (int d = 0; d < ND; d++) begin
      if (ack_n[d] == m_seq[d][4]) begin
        ack_wait[d] = -1;
      end else begin
        if (ack_wait[d] < 0) ack_wait[d] = rand_bits(3);
        if (ack_wait[d] == 0) begin
          ack_n[d] <= m_seq[d][4];
          ack_wait[d] = -1;
        end else begin
          ack_wait[d]--;
        end
      end
    end
  endtask

  task automatic model_step();
    logic [ND-1:0] req;
    logic iso_n;
    req[0] = cpu_pd_en_i & core_sleep_i & (exp_vec(m_pend, m_piso, irq_timer0_i) == '0);
    req[1] = periph_off_i;
    req[ND-1:2] = bank_off_i;
    iso_n = m_seq[1][3];
    for (int d = 0; d < ND; d++) begin
      m_seq[d] = seq_out(m_state[d]);
      m_state[d] = seq_next(m_state[d], req[d], ack_n[d]);
    end
    m_piso = iso_n ? periph_irq_i : '0;
    m_gpio = iso_n ? periph_gpio_i : '0;
    for (int i = 0; i < 14; i++)
      m_pend[i] = fast_src_i[i] | (m_pend[i] & !(irq_ack_i && irq_id_i == 5'(16 + i)));
  endtask

  task automatic drive_random();
    cpu_pd_en_i  <= 1'(rand_bits(1));
    core_sleep_i <= 1'(rand_bits(1));
    if (rand_bits(4) == 0) periph_off_i <= !periph_off_i;
    for (int b = 0; b < `NUM_BANKS; b++)
      if (rand_bits(4) == 0) bank_off_i[b] <= !bank_off_i[b];
    fast_src_i    <= 14'(rand_bits(14) & rand_bits(14) & rand_bits(14));
    irq_ack_i     <= 1'(rand_bits(1));
    irq_id_i      <= 5'(rand_bits(5)) | 5'h10;
    irq_timer0_i  <= 1'(rand_bits(1));
    periph_irq_i  <= 2'(rand_bits(2));
    periph_gpio_i <= {24'(rand_bits(24)), 24'(rand_bits(24))};
    ndmreset_i    <= (rand_bits(5) == 0);
  endtask

  initial begin
    clk_i = 0;
    forever #4 clk_i = !clk_i;
  end

  always @(negedge clk_i) begin
    if (chk_en) begin
      check_val("cpu_pwr",
                64'({m_seq[0][4:3], m_seq[0][2] & !ndmreset_i, m_seq[0][1:0]}),
                64'(cpu_pwr_o));
      check_val("periph_pwr",
                64'({m_seq[1][4:3], m_seq[1][2] & !ndmreset_i, m_seq[1][1:0]}),
                64'(periph_pwr_o));
      for (int b = 0; b < `NUM_BANKS; b++)
        check_val("bank_pwr",
                  64'({m_seq[b+2][4:3], m_seq[b+2][2] & !ndmreset_i, m_seq[b+2][1:0]}),
                  64'(bank_pwr_o[b]));
      check_val("irq_vector", 64'(exp_vec(m_pend, m_piso, irq_timer0_i)), 64'(irq_o));
      check_val("gpio_iso", 64'(m_gpio), 64'(gpio_o));
    end
  end

  initial begin
    #(2 * N_TOTAL * 8);
    $display("timeout, the stimulus did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    reset_i       = 1;
    ndmreset_i    = 0;
    cpu_pd_en_i   = 0;
    core_sleep_i  = 0;
    periph_off_i  = 0;
    bank_off_i    = '0;
    ack_n         = '1;
    fast_src_i    = '0;
    periph_irq_i  = '0;
    irq_timer0_i  = 0;
    irq_ack_i     = 0;
    irq_id_i      = '0;
    periph_gpio_i = '0;
    m_pend        = '0;
    m_piso        = '0;
    m_gpio        = '0;
    for (int d = 0; d < ND; d++) begin
      m_state[d] = S_ON;
      m_seq[d] = '1;
      ack_wait[d] = -1;
    end
    repeat (5) @(posedge clk_i);
    reset_i <= 0;
    chk_en = 1;
    for (int cyc = 0; cyc < N_TOTAL; cyc++) begin
      @(posedge clk_i);
      ack_step();
      model_step();
      if (cyc < N_RAND1 || cyc >= N_RAND1 + N_QUIET + N_HOLD) begin
        drive_random();
      end else begin
        // sleep with quiet interrupts, then one fast pulse
        cpu_pd_en_i  <= 1;
        core_sleep_i <= 1;
        ndmreset_i   <= 0;
        irq_timer0_i <= 0;
        periph_irq_i <= '0;
        irq_ack_i    <= (cyc < N_RAND1 + N_QUIET);
        irq_id_i     <= 5'(16 + cyc % 15);
        fast_src_i   <= (cyc == N_RAND1 + N_QUIET) ? 14'h1 : 14'h0;
      end
      // cpu switch open by the end of the quiet window
      if (cyc == N_RAND1 + N_QUIET - 1) begin
        @(negedge clk_i);
        check_val("cpu_sleep", 64'(1'b0), 64'(cpu_pwr_o.pwrgate_en_n));
      end
      // cpu domain fully on again by the end of the hold window
      if (cyc == N_RAND1 + N_QUIET + N_HOLD - 1) begin
        @(negedge clk_i);
        check_val("cpu_wake", 64'(5'h1f), 64'(cpu_pwr_o));
      end
    end
    @(negedge clk_i);
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: mini_mcu_ctrl_assert.sv
// --------------------
// mcu control assertions
// sequencing order and peripheral isolation
// --------------------
`timescale 1ns/10ps

module mini_mcu_ctrl_assert (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   ndmreset_i,
  input mcu_pkg::pwr_ctrl_out_t cpu_pwr_o,
  input mcu_pkg::pwr_ctrl_out_t periph_pwr_o,
  input mcu_pkg::gpio_pad_t     gpio_o
);

  // isolation drops only after the domain reset is released
  a_cpu_iso_release: assert property (@(posedge clk_i) disable iff (reset_i || ndmreset_i)
    $rose(cpu_pwr_o.isogate_en_n) |-> cpu_pwr_o.rst_n) else $error("cpu iso released in reset");
  a_per_iso_release: assert property (@(posedge clk_i) disable iff (reset_i || ndmreset_i)
    $rose(periph_pwr_o.isogate_en_n) |-> periph_pwr_o.rst_n) else $error("periph iso in reset");

  // switch opens only behind isolation
  a_cpu_sw_iso: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(cpu_pwr_o.pwrgate_en_n) |-> !cpu_pwr_o.isogate_en_n) else $error("cpu switch off");
  a_per_sw_iso: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(periph_pwr_o.pwrgate_en_n) |-> !periph_pwr_o.isogate_en_n) else $error("periph off");

  a_gpio_clamp: assert property (@(posedge clk_i) disable iff (reset_i)
    !periph_pwr_o.isogate_en_n |=> gpio_o == '0) else $error("gpio not clamped");

endmodule

bind mini_mcu_ctrl mini_mcu_ctrl_assert u_assert (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .ndmreset_i   (ndmreset_i),
  .cpu_pwr_o    (cpu_pwr_o),
  .periph_pwr_o (periph_pwr_o),
  .gpio_o       (gpio_o)
);

// File: mini_mcu_ctrl.sv
// --------------------
// mcu control top
// power, isolation and interrupt control
// --------------------
`timescale 1ns/10ps
`include "mcu_settings.svh"

module mini_mcu_ctrl (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   ndmreset_i,
  input  logic                                   cpu_pd_en_i,
  input  logic                                   core_sleep_i,
  input  logic                                   periph_off_i,
  input  logic [`NUM_BANKS-1:0]                  bank_off_i,
  input  logic                                   cpu_ack_ni,
  input  logic                                   periph_ack_ni,
  input  logic [`NUM_BANKS-1:0]                  bank_ack_ni,
  output mcu_pkg::pwr_ctrl_out_t                 cpu_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t                 periph_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t [`NUM_BANKS-1:0] bank_pwr_o,
  input  mcu_pkg::fast_src_t                     fast_src_i,
  input  mcu_pkg::periph_irq_t                   periph_irq_i,
  input  logic                                   irq_timer0_i,
  input  logic                                   irq_ack_i,
  input  logic [4:0]                             irq_id_i,
  input  mcu_pkg::gpio_pad_t                     periph_gpio_i,
  output mcu_pkg::gpio_pad_t                     gpio_o,
  output logic [`IRQ_W-1:0]                      irq_o
);

  import mcu_pkg::*;

  periph_irq_t periph_irq_iso;
  logic        irq_pending;

  power_manager u_pwr (
    .clk_i,
    .reset_i,
    .ndmreset_i,
    .cpu_pd_en_i,
    .core_sleep_i,
    .irq_pending_i (irq_pending),
    .periph_off_i,
    .bank_off_i,
    .cpu_ack_ni,
    .periph_ack_ni,
    .bank_ack_ni,
    .cpu_pwr_o,
    .periph_pwr_o,
    .bank_pwr_o
  );

  // peripheral domain boundary
  domain_iso_reg #(.T(gpio_pad_t)) u_gpio_iso (
    .clk_i,
    .reset_i,
    .isolate_ni (periph_pwr_o.isogate_en_n),
    .data_i     (periph_gpio_i),
    .data_o     (gpio_o)
  );

  domain_iso_reg #(.T(periph_irq_t)) u_irq_iso (
    .clk_i,
    .reset_i,
    .isolate_ni (periph_pwr_o.isogate_en_n),
    .data_i     (periph_irq_i),
    .data_o     (periph_irq_iso)
  );

  irq_ctrl u_irq (
    .clk_i,
    .reset_i,
    .fast_src_i,
    .periph_irq_i  (periph_irq_iso),
    .irq_timer0_i,
    .irq_ack_i,
    .irq_id_i,
    .irq_o,
    .irq_pending_o (irq_pending)
  );

endmodule

// File: domain_iso_reg.sv
// --------------------
// isolation register
// clamps a domain payload to zero while isolated
// --------------------
`timescale 1ns/10ps

module domain_iso_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic isolate_ni,
  input  T     data_i,
  output T     data_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i || !isolate_ni) begin
      data_o <= '0;
    end else begin
      data_o <= data_i;
    end
  end

endmodule

// File: irq_ctrl.sv
// --------------------
// interrupt control
// fast pending latches and core vector assembly
// --------------------
`timescale 1ns/10ps
`include "mcu_settings.svh"

module irq_ctrl (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mcu_pkg::fast_src_t   fast_src_i,
  input  mcu_pkg::periph_irq_t periph_irq_i,
  input  logic                 irq_timer0_i,
  input  logic                 irq_ack_i,
  input  logic [4:0]           irq_id_i,
  output logic [`IRQ_W-1:0]    irq_o,
  output logic                 irq_pending_o
);

  logic [`FAST_IRQ_W-1:0] fast_src;
  logic [`FAST_IRQ_W-1:0] fast_clr;
  logic [`FAST_IRQ_W-1:0] fast_pend_q;

  // top fast line has no source
  assign fast_src = {1'b0, fast_src_i};

  for (genvar i = 0; i < `FAST_IRQ_W; i++) begin : g_clr
    assign fast_clr[i] = irq_ack_i && (irq_id_i == 5'(`IRQ_FAST_BASE + i));
  end

  // a new source event wins over a same-cycle ack
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fast_pend_q <= '0;
    end else begin
      fast_pend_q <= fast_src | (fast_pend_q & ~fast_clr);
    end
  end

  always_comb begin
    irq_o                                   = '0;
    irq_o[`IRQ_MSIP_BIT]                    = periph_irq_i.msip;
    irq_o[`IRQ_MTIP_BIT]                    = irq_timer0_i;
    irq_o[`IRQ_MEIP_BIT]                    = periph_irq_i.plic;
    irq_o[`IRQ_FAST_BASE +: `FAST_IRQ_W]    = fast_pend_q;
  end

  assign irq_pending_o = |irq_o;

endmodule

// File: power_manager.sv
// --------------------
// power manager
// cpu, peripheral and bank sequencers with debug reset merge
// --------------------
`timescale 1ns/10ps
`include "mcu_settings.svh"

module power_manager (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   ndmreset_i,
  input  logic                                   cpu_pd_en_i,
  input  logic                                   core_sleep_i,
  input  logic                                   irq_pending_i,
  input  logic                                   periph_off_i,
  input  logic [`NUM_BANKS-1:0]                  bank_off_i,
  input  logic                                   cpu_ack_ni,
  input  logic                                   periph_ack_ni,
  input  logic [`NUM_BANKS-1:0]                  bank_ack_ni,
  output mcu_pkg::pwr_ctrl_out_t                 cpu_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t                 periph_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t [`NUM_BANKS-1:0] bank_pwr_o
);

  import mcu_pkg::*;

  pwr_ctrl_out_t                  cpu_seq;
  pwr_ctrl_out_t                  periph_seq;
  pwr_ctrl_out_t [`NUM_BANKS-1:0] bank_seq;
  logic                           cpu_off_req;

  // debug non-debug reset pulls the domain reset low
  function automatic pwr_ctrl_out_t merge_ndm(input pwr_ctrl_out_t p, input logic ndm);
    pwr_ctrl_out_t m;
    m       = p;
    m.rst_n = p.rst_n & ~ndm;
    return m;
  endfunction

  // core asleep, power-down allowed, nothing pending
  assign cpu_off_req = cpu_pd_en_i & core_sleep_i & ~irq_pending_i;

  power_domain_ctrl u_cpu (
    .clk_i,
    .reset_i,
    .off_req_i      (cpu_off_req),
    .pwrgate_ack_ni (cpu_ack_ni),
    .pwr_o          (cpu_seq)
  );

  power_domain_ctrl u_periph (
    .clk_i,
    .reset_i,
    .off_req_i      (periph_off_i),
    .pwrgate_ack_ni (periph_ack_ni),
    .pwr_o          (periph_seq)
  );

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : u_bank
    power_domain_ctrl u_dom (
      .clk_i,
      .reset_i,
      .off_req_i      (bank_off_i[b]),
      .pwrgate_ack_ni (bank_ack_ni[b]),
      .pwr_o          (bank_seq[b])
    );

    assign bank_pwr_o[b] = merge_ndm(bank_seq[b], ndmreset_i);
  end

  assign cpu_pwr_o    = merge_ndm(cpu_seq, ndmreset_i);
  assign periph_pwr_o = merge_ndm(periph_seq, ndmreset_i);

endmodule

// File: power_domain_ctrl.sv
// --------------------
// power domain sequencer
// steps clock gate, isolation, reset and power switch
// --------------------
`timescale 1ns/10ps

module power_domain_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  off_req_i,
  input  logic                  pwrgate_ack_ni,
  output mcu_pkg::pwr_ctrl_out_t pwr_o
);

  import mcu_pkg::*;

  typedef enum logic [3:0] {
    ON,
    CLK_OFF,
    ISO_ON,
    RST_ON,
    SW_OFF,
    OFF,
    SW_ON,
    RST_OFF,
    ISO_OFF
  } pd_state_e;

  localparam pwr_ctrl_out_t PWR_ALL_ON = '1;

  pd_state_e     state_q;
  pd_state_e     state_d;
  pwr_ctrl_out_t pwr_d;

  // requests only matter in ON and OFF
  always_comb begin
    state_d = state_q;
    case (state_q)
      ON:      if (off_req_i) state_d = CLK_OFF;
      CLK_OFF: state_d = ISO_ON;
      ISO_ON:  state_d = RST_ON;
      RST_ON:  state_d = SW_OFF;
      SW_OFF:  if (!pwrgate_ack_ni) state_d = OFF;
      OFF:     if (!off_req_i) state_d = SW_ON;
      SW_ON:   if (pwrgate_ack_ni) state_d = RST_OFF;
      RST_OFF: state_d = ISO_OFF;
      ISO_OFF: state_d = ON;
      default: state_d = ON;
    endcase
  end

  // output levels for each state
  always_comb begin
    pwr_d              = PWR_ALL_ON;
    pwr_d.clkgate_en_n = (state_q == ON);
    pwr_d.isogate_en_n = state_q inside {ON, CLK_OFF, ISO_OFF};
    pwr_d.rst_n        = state_q inside {ON, CLK_OFF, ISO_ON, RST_OFF, ISO_OFF};
    pwr_d.pwrgate_en_n = !(state_q inside {SW_OFF, OFF});
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ON;
      pwr_o   <= PWR_ALL_ON;
    end else begin
      state_q <= state_d;
      // one cycle behind the state
      pwr_o   <= pwr_d;
    end
  end

endmodule

// File: mcu_pkg.sv
// --------------------
// mcu control types
// power control and peripheral boundary structs
// --------------------
`include "mcu_settings.svh"

package mcu_pkg;

  // per domain sequencer outputs, all active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    // reserved, always 1
    logic rsvd_n;
  } pwr_ctrl_out_t;

  // peripheral gpio pads
  typedef struct packed {
    logic [`GPIO_W-1:0] out;
    logic [`GPIO_W-1:0] oe;
  } gpio_pad_t;

  // plic and msip from the peripheral domain
  typedef struct packed {
    logic plic;
    logic msip;
  } periph_irq_t;

  // fast sources, timer1 sits at bit 0
  typedef struct packed {
    logic [7:0] gpio_ao;
    logic       spi_flash;
    logic       spi;
    logic       dma_done;
    logic       timer3;
    logic       timer2;
    logic       timer1;
  } fast_src_t;

endpackage

// File: mcu_settings.svh
// --------------------
// mcu control settings
// sizes and interrupt vector positions
// --------------------
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// switchable memory banks
`define NUM_BANKS 2

// peripheral domain pads 8 to 31
`define GPIO_W 24

// core interrupt vector
`define IRQ_W 32
`define FAST_IRQ_W 15

// standard machine interrupt bits
`define IRQ_MSIP_BIT 3
`define IRQ_MTIP_BIT 7
`define IRQ_MEIP_BIT 11

// fast lines start here
`define IRQ_FAST_BASE 16

`endif
